// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_decode
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: help build run test clean

help:
	@echo "targets:"
	@echo "  build  compile the testbench with Verilator"
	@echo "  run    run the simulation, output in $(LOG)"
	@echo "  test   build, run and report pass or fail"
	@echo "  clean  remove build output and log"

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)

test: run
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/decode_control.sv
// decode stage control
// state machine with the reset clear sweep, jump epoch, issue/stall/drop
// decisions, exit handling and the retired instruction count
`timescale 1ns/1ns
`default_nettype none

module decode_control import decode_pkg::*; (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input jump_flag_t inst_jump_flag,
    input logic jump_valid,
    input logic jump_mispredict,
    input logic operands_ready,
    input reg_value_t rs1_value,
    decode_fields_if.sink fields,
    output logic inst_ready,
    output logic issue_en,
    output logic clear_en,
    output reg_addr_t clear_addr,
    output jump_flag_t jump_flag,
    output logic exit_flag,
    output logic [7:0] exit_code,
    output retired_count_t retired_count
);

    decode_state_t state, next_state;
    reg_addr_t reset_count;
    logic stale;
    logic exit_op;
    logic take;
    logic take_exit;

    always_comb begin
        clear_en = (state == ST_RESET);
        clear_addr = reset_count;
        exit_flag = (state == ST_EXIT);

        // flag is compared against the registered epoch
        stale = (inst_jump_flag != jump_flag);
        exit_op = (fields.op_class == OP_EBREAK) || (fields.op_class == OP_ILLEGAL);

        // stale words are swallowed without waiting on hazards
        case (state)
            ST_NORMAL: inst_ready = stale || operands_ready;
            ST_EXIT: inst_ready = 1'b1;
            default: inst_ready = 1'b0;
        endcase

        // drops are accepted but go no further
        take = inst_valid && inst_ready && (state == ST_NORMAL) && !stale;
        issue_en = take && !exit_op;
        take_exit = take && exit_op;

        next_state = state;
        case (state)
            ST_RESET: begin
                // last register cleared this cycle
                if (reset_count == reg_addr_t'(num_regs - 1)) begin
                    next_state = ST_NORMAL;
                end
            end
            ST_NORMAL: begin
                if (take_exit) begin
                    next_state = ST_EXIT;
                end
            end
            ST_EXIT: begin
                next_state = ST_EXIT;
            end
            default: begin
                next_state = ST_RESET;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
            reset_count <= '0;
            jump_flag <= '0;
            exit_code <= '0;
            retired_count <= '0;
        end else begin
            state <= next_state;
            if (state == ST_RESET) begin
                reset_count <= reset_count + 1'b1;
            end
            // new epoch applies from the next cycle
            if (jump_valid && jump_mispredict) begin
                jump_flag <= jump_flag + 1'b1;
            end
            if (take_exit) begin
                // ebreak returns the low byte of a0
                exit_code <= (fields.op_class == OP_EBREAK) ? rs1_value[7:0] : exit_code_illegal;
            end
            if (issue_en) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_fields_if.sv
// decoded instruction fields
// driven by the decoder, read by control, scoreboard, register file and issue
`timescale 1ns/1ns
`default_nettype none

interface decode_fields_if import decode_pkg::*; ();

    op_class_t op_class;
    // rd is zero whenever the instruction writes nothing
    reg_addr_t rd;
    // source addresses, zero when the operand is unused
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_value_t imm;
    funct3_t funct3;
    logic writes_rd;

    modport source (
        output op_class, rd, rs1, rs2, imm, funct3, writes_rd
    );

    modport sink (
        input op_class, rd, rs1, rs2, imm, funct3, writes_rd
    );

endinterface

`default_nettype wire

// File: hw/decode_pkg.sv
// decode stage shared definitions
// widths, tag and epoch types, state and opcode-class enums,
// RV32I major opcodes and the layout of the issued execute command
`default_nettype none

package decode_pkg;

    // register file geometry
    localparam int xlen = 32;
    localparam int num_regs = 32;

    typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
    typedef logic [xlen-1:0] reg_value_t;
    typedef logic [2:0] funct3_t;

    // per register write count, wraps freely
    typedef logic [2:0] reg_tag_t;
    // epoch, one step per mispredict
    typedef logic [1:0] jump_flag_t;
    typedef logic [31:0] retired_count_t;

    typedef enum logic [1:0] {
        ST_RESET = 2'b00,
        ST_NORMAL = 2'b01,
        ST_EXIT = 2'b11
    } decode_state_t;

    typedef enum logic [3:0] {
        OP_ALU_REG = 4'd0,
        OP_ALU_IMM = 4'd1,
        OP_LOAD = 4'd2,
        OP_STORE = 4'd3,
        OP_BRANCH = 4'd4,
        OP_JAL = 4'd5,
        OP_JALR = 4'd6,
        OP_LUI = 4'd7,
        OP_AUIPC = 4'd8,
        OP_EBREAK = 4'd9,
        OP_ILLEGAL = 4'd15
    } op_class_t;

    // RV32I major opcodes
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_auipc = 7'b0010111;
    localparam logic [6:0] opcode_store = 7'b0100011;
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jalr = 7'b1100111;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // the only system word still decoded
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    // a0 holds the exit code on ebreak
    localparam reg_addr_t exit_reg = 5'd10;
    localparam logic [7:0] exit_code_illegal = 8'd1;

    typedef struct packed {
        op_class_t op_class;
        funct3_t funct3;
        reg_addr_t rd;
        reg_tag_t rd_tag;
        reg_value_t rs1_value;
        reg_value_t rs2_value;
        reg_value_t imm;
        reg_value_t pc;
        jump_flag_t jump_flag;
    } exec_cmd_t;

endpackage

`default_nettype wire

// File: hw/decode_top.sv
// decode and issue stage top level
// wires the decoder, register file, scoreboard, control and issue register
`timescale 1ns/1ns
`default_nettype none

module decode_top import decode_pkg::*; (
    input logic clk,
    input logic reset,

    // instruction stream
    input logic inst_valid,
    input logic [31:0] inst_data,
    input reg_value_t inst_pc,
    input jump_flag_t inst_jump_flag,
    output logic inst_ready,

    // writeback strobe
    input logic wb_valid,
    input reg_addr_t wb_addr,
    input reg_value_t wb_value,

    // jump strobe from execute
    input logic jump_valid,
    input logic jump_mispredict,

    output logic exec_valid,
    output exec_cmd_t exec_cmd,
    output logic exit_flag,
    output logic [7:0] exit_code,
    output retired_count_t retired_count
);

    logic issue_en;
    logic clear_en;
    reg_addr_t clear_addr;
    logic operands_ready;
    reg_tag_t rd_tag;
    reg_value_t rs1_value;
    reg_value_t rs2_value;
    jump_flag_t jump_flag;

    decode_fields_if fields ();

    inst_decoder inst_decoder_inst (
        .inst_data,
        .fields(fields.source)
    );

    reg_file reg_file_inst (
        .clk, .reset,
        .clear_en, .clear_addr,
        .wb_valid, .wb_addr, .wb_value,
        .fields(fields.sink),
        .rs1_value, .rs2_value
    );

    reg_scoreboard reg_scoreboard_inst (
        .clk, .reset,
        .clear_en, .clear_addr,
        .issue_en,
        .wb_valid, .wb_addr,
        .fields(fields.sink),
        .rd_tag, .operands_ready
    );

    decode_control decode_control_inst (
        .clk, .reset,
        .inst_valid, .inst_jump_flag,
        .jump_valid, .jump_mispredict,
        .operands_ready, .rs1_value,
        .fields(fields.sink),
        .inst_ready, .issue_en,
        .clear_en, .clear_addr,
        .jump_flag,
        .exit_flag, .exit_code,
        .retired_count
    );

    exec_issue exec_issue_inst (
        .clk, .reset,
        .issue_en,
        .fields(fields.sink),
        .rd_tag, .rs1_value, .rs2_value,
        .inst_pc, .jump_flag,
        .exec_valid, .exec_cmd
    );

endmodule

`default_nettype wire

// File: hw/exec_issue.sv
// execute command register
// captures the assembled command on issue and strobes exec_valid
// for exactly one cycle, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module exec_issue import decode_pkg::*; (
    input logic clk,
    input logic reset,
    input logic issue_en,
    decode_fields_if.sink fields,
    input reg_tag_t rd_tag,
    input reg_value_t rs1_value,
    input reg_value_t rs2_value,
    input reg_value_t inst_pc,
    input jump_flag_t jump_flag,
    output logic exec_valid,
    output exec_cmd_t exec_cmd
);

    exec_cmd_t next_cmd;

    // assemble from decoded fields and operand reads
    always_comb begin
        next_cmd.op_class = fields.op_class;
        next_cmd.funct3 = fields.funct3;
        next_cmd.rd = fields.rd;
        next_cmd.rd_tag = rd_tag;
        next_cmd.rs1_value = rs1_value;
        next_cmd.rs2_value = rs2_value;
        next_cmd.imm = fields.imm;
        next_cmd.pc = inst_pc;
        next_cmd.jump_flag = jump_flag;
    end

    // strobe, one cycle per issue
    always_ff @(posedge clk) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= issue_en;
        end
    end

    // payload only, held until the next issue
    always_ff @(posedge clk) begin
        if (issue_en) begin
            exec_cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
// RV32I instruction decoder
// splits the word into fields, builds the immediate and classifies the opcode
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input logic [31:0] inst_data,
    decode_fields_if.source fields
);

    logic [6:0] opcode;
    funct3_t funct3;
    logic [6:0] funct7;
    reg_addr_t rd_raw;
    reg_addr_t rs1_raw;
    reg_addr_t rs2_raw;
    reg_value_t imm_i, imm_s, imm_b, imm_u, imm_j;
    op_class_t op_class;
    logic uses_rs1, uses_rs2, has_rd;
    logic writes_rd;

    assign opcode = inst_data[6:0];
    assign rd_raw = inst_data[11:7];
    assign funct3 = inst_data[14:12];
    assign rs1_raw = inst_data[19:15];
    assign rs2_raw = inst_data[24:20];
    assign funct7 = inst_data[31:25];

    // sign extended immediates for every format
    assign imm_i = {{20{inst_data[31]}}, inst_data[31:20]};
    assign imm_s = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
    assign imm_b = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                    inst_data[30:25], inst_data[11:8], 1'b0};
    assign imm_u = {inst_data[31:12], 12'b0};
    assign imm_j = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                    inst_data[20], inst_data[30:21], 1'b0};

    always_comb begin
        op_class = OP_ILLEGAL;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        has_rd = 1'b0;
        case (opcode)
            opcode_op: begin
                // only add/sub and srl/sra take funct7 0x20
                if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    op_class = OP_ALU_REG;
                end
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                has_rd = 1'b1;
            end
            opcode_op_imm: begin
                // shift amounts need a clean funct7
                if (!(funct3 == 3'd1 && funct7 != 7'h00) &&
                        !(funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20)) begin
                    op_class = OP_ALU_IMM;
                end
                uses_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            opcode_load: begin
                if (funct3 != 3'd3 && funct3 < 3'd6) begin
                    op_class = OP_LOAD;
                end
                uses_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            opcode_store: begin
                if (funct3 <= 3'd2) begin
                    op_class = OP_STORE;
                end
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            opcode_branch: begin
                if (funct3 != 3'd2 && funct3 != 3'd3) begin
                    op_class = OP_BRANCH;
                end
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            opcode_jalr: begin
                if (funct3 == 3'd0) begin
                    op_class = OP_JALR;
                end
                uses_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            opcode_jal: begin
                op_class = OP_JAL;
                has_rd = 1'b1;
            end
            opcode_lui: begin
                op_class = OP_LUI;
                has_rd = 1'b1;
            end
            opcode_auipc: begin
                op_class = OP_AUIPC;
                has_rd = 1'b1;
            end
            opcode_system: begin
                // ecall and csr access are not supported here
                if (inst_data == ebreak_word) begin
                    op_class = OP_EBREAK;
                end
            end
            default: begin
                op_class = OP_ILLEGAL;
            end
        endcase
    end

    // illegal words touch no register, so they never stall
    assign writes_rd = has_rd && (rd_raw != '0) && (op_class != OP_ILLEGAL);

    assign fields.op_class = op_class;
    assign fields.writes_rd = writes_rd;
    assign fields.funct3 = funct3;
    assign fields.rd = writes_rd ? rd_raw : '0;
    // ebreak reads a0 for the exit code
    assign fields.rs1 = (op_class == OP_EBREAK) ? exit_reg :
                        (uses_rs1 && op_class != OP_ILLEGAL) ? rs1_raw : '0;
    assign fields.rs2 = (uses_rs2 && op_class != OP_ILLEGAL) ? rs2_raw : '0;

    always_comb begin
        case (op_class)
            OP_ALU_IMM, OP_LOAD, OP_JALR: fields.imm = imm_i;
            OP_STORE: fields.imm = imm_s;
            OP_BRANCH: fields.imm = imm_b;
            OP_LUI, OP_AUIPC: fields.imm = imm_u;
            OP_JAL: fields.imm = imm_j;
            default: fields.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// architectural register file, 32 x 32
// two combinational reads, one write shared by the clear sweep and writeback
`timescale 1ns/1ns
`default_nettype none

module reg_file import decode_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clear_en,
    input reg_addr_t clear_addr,
    input logic wb_valid,
    input reg_addr_t wb_addr,
    input reg_value_t wb_value,
    decode_fields_if.sink fields,
    output reg_value_t rs1_value,
    output reg_value_t rs2_value
);

    reg_value_t regs [num_regs];

    always_ff @(posedge clk) begin
        // sweep zeroes one register per cycle
        if (clear_en) begin
            regs[clear_addr] <= '0;
        end else if (wb_valid && !reset && wb_addr != '0) begin
            // x0 stays zero
            regs[wb_addr] <= wb_value;
        end
    end

    // writes land on the edge, reads next cycle see them
    assign rs1_value = regs[fields.rs1];
    assign rs2_value = regs[fields.rs2];

endmodule

`default_nettype wire

// File: hw/reg_scoreboard.sv
// register scoreboard
// front tags count issued writes, rear tags count writebacks per register,
// a register is busy while the two differ
`timescale 1ns/1ns
`default_nettype none

module reg_scoreboard import decode_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clear_en,
    input reg_addr_t clear_addr,
    input logic issue_en,
    input logic wb_valid,
    input reg_addr_t wb_addr,
    decode_fields_if.sink fields,
    output reg_tag_t rd_tag,
    output logic operands_ready
);

    reg_tag_t front_tags [num_regs];
    reg_tag_t rear_tags [num_regs];
    logic rs1_busy, rs2_busy, rd_busy;

    // front table, bumped when a writing instruction issues
    always_ff @(posedge clk) begin
        if (clear_en) begin
            front_tags[clear_addr] <= '0;
        end else if (issue_en && fields.writes_rd) begin
            front_tags[fields.rd] <= front_tags[fields.rd] + 1'b1;
        end
    end

    // rear table, bumped by every writeback
    always_ff @(posedge clk) begin
        if (clear_en) begin
            rear_tags[clear_addr] <= '0;
        end else if (wb_valid && !reset && wb_addr != '0) begin
            rear_tags[wb_addr] <= rear_tags[wb_addr] + 1'b1;
        end
    end

    // x0 never has a write outstanding
    always_comb begin
        rs1_busy = (fields.rs1 != '0) && (front_tags[fields.rs1] != rear_tags[fields.rs1]);
        rs2_busy = (fields.rs2 != '0) && (front_tags[fields.rs2] != rear_tags[fields.rs2]);
        // waiting on rd keeps writebacks to one register in order
        rd_busy = (fields.rd != '0) && (front_tags[fields.rd] != rear_tags[fields.rd]);
        operands_ready = !(rs1_busy || rs2_busy || rd_busy);
    end

    // tag before the increment, i.e. number of earlier issues to rd
    assign rd_tag = front_tags[fields.rd];

endmodule

`default_nettype wire

// File: project.f
hw/decode_pkg.sv
hw/decode_fields_if.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/reg_scoreboard.sv
hw/decode_control.sv
hw/exec_issue.sv
hw/decode_top.sv
verif/decode_checker.sv
verif/tb_decode.sv

// File: verif/decode_checker.sv
// decode stage result checker
// holds the queue of expected execute commands, compares every exec_valid
// strobe against it and counts errors for the closing report
`timescale 1ns/1ns
`default_nettype none

module decode_checker import decode_pkg::*; (
    input logic clk,
    input logic exec_valid,
    input exec_cmd_t exec_cmd
);

    exec_cmd_t expected_q[$];
    int error_count = 0;
    int command_count = 0;

    // queued in issue order by the driver
    task automatic push_expected(input exec_cmd_t cmd);
        expected_q.push_back(cmd);
    endtask

    // one value against its expectation, both shown in hex
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    // anything left over never came out of the stage
    task automatic check_drained();
        if (expected_q.size() != 0) begin
            $display("%0d expected commands were never issued", expected_q.size());
            error_count++;
        end
    endtask

    // strobe and payload are stable at the falling edge
    always @(negedge clk) begin
        exec_cmd_t exp;
        if (exec_valid === 1'b1) begin
            command_count++;
            if (expected_q.size() == 0) begin
                $display("a command was issued where none was expected, pc %h at %0t",
                         exec_cmd.pc, $time);
                error_count++;
            end else begin
                exp = expected_q.pop_front();
                check_value("exec_cmd.op_class", 32'(exec_cmd.op_class), 32'(exp.op_class));
                check_value("exec_cmd.funct3", 32'(exec_cmd.funct3), 32'(exp.funct3));
                check_value("exec_cmd.rd", 32'(exec_cmd.rd), 32'(exp.rd));
                check_value("exec_cmd.rd_tag", 32'(exec_cmd.rd_tag), 32'(exp.rd_tag));
                check_value("exec_cmd.rs1_value", exec_cmd.rs1_value, exp.rs1_value);
                check_value("exec_cmd.rs2_value", exec_cmd.rs2_value, exp.rs2_value);
                check_value("exec_cmd.imm", exec_cmd.imm, exp.imm);
                check_value("exec_cmd.pc", exec_cmd.pc, exp.pc);
                check_value("exec_cmd.jump_flag", 32'(exec_cmd.jump_flag),
                            32'(exp.jump_flag));
            end
        end else if (exec_valid !== 1'b0) begin
            $display("exec_valid is unknown at %0t", $time);
            error_count++;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_decode.sv
// decode stage testbench
// runs a table of instructions with writeback and jump strobes through
// the stage, then a second reset run for the illegal opcode exit
`timescale 1ns/1ns
`default_nettype none

module tb_decode import decode_pkg::*; ();

    localparam int num_rows = 10;
    localparam int timeout_cycles = 40 * num_rows + 100;

    // row kinds
    localparam int kind_issue = 0;
    localparam int kind_drop = 1;
    localparam int kind_exit = 2;
    // when the writeback strobe of a row fires
    localparam int wb_none = 0;
    localparam int wb_before = 1;
    localparam int wb_during = 2;

    typedef struct {
        logic [31:0] word;
        logic [31:0] pc;
        logic [1:0] jflag;
        int wb_mode;
        logic [4:0] wb_addr;
        logic [31:0] wb_value;
        bit jump_en;
        int kind;
        op_class_t cls;
        logic [4:0] rd;
        logic [2:0] tag;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] imm;
        logic [7:0] code;
    } stim_row_t;

    logic clk;
    logic reset;
    logic inst_valid;
    logic [31:0] inst_data;
    logic [31:0] inst_pc;
    logic [1:0] inst_jump_flag;
    logic inst_ready;
    logic wb_valid;
    logic [4:0] wb_addr;
    logic [31:0] wb_value;
    logic jump_valid;
    logic jump_mispredict;
    logic exec_valid;
    exec_cmd_t exec_cmd;
    logic exit_flag;
    logic [7:0] exit_code;
    logic [31:0] retired_count;

    stim_row_t rows[$];
    jump_flag_t epoch;
    int expected_retired;
    int issued_rows;
    int cycle_count = 0;

    decode_top UUT (
        .clk, .reset,
        .inst_valid, .inst_data, .inst_pc, .inst_jump_flag, .inst_ready,
        .wb_valid, .wb_addr, .wb_value,
        .jump_valid, .jump_mispredict,
        .exec_valid, .exec_cmd,
        .exit_flag, .exit_code,
        .retired_count
    );

    decode_checker checks (
        .clk,
        .exec_valid,
        .exec_cmd
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the stage stopped responding", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // RV32I R and I format encodings
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic [31:0] pc,
            input logic [1:0] jflag, input int wb_mode, input logic [4:0] wb_a,
            input logic [31:0] wb_v, input bit jump_en, input int kind,
            input op_class_t cls, input logic [4:0] rd, input logic [2:0] tag,
            input logic [31:0] rs1v, input logic [31:0] rs2v, input logic [31:0] imm,
            input logic [7:0] code);
        stim_row_t r;
        r.word = word;
        r.pc = pc;
        r.jflag = jflag;
        r.wb_mode = wb_mode;
        r.wb_addr = wb_a;
        r.wb_value = wb_v;
        r.jump_en = jump_en;
        r.kind = kind;
        r.cls = cls;
        r.rd = rd;
        r.tag = tag;
        r.rs1v = rs1v;
        r.rs2v = rs2v;
        r.imm = imm;
        r.code = code;
        rows.push_back(r);
    endtask

    // one cycle strobe starting at the current falling edge
    task automatic pulse_writeback(input logic [4:0] addr, input logic [31:0] value);
        wb_valid = 1'b1;
        wb_addr = addr;
        wb_value = value;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic pulse_mispredict();
        jump_valid = 1'b1;
        jump_mispredict = 1'b1;
        @(negedge clk);
        jump_valid = 1'b0;
        jump_mispredict = 1'b0;
        epoch = epoch + 1'b1;
    endtask

    // reset, then the 32 cycle clear sweep with ready held low
    task automatic reset_and_sweep();
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        epoch = '0;
        expected_retired = 0;
        repeat (31) begin
            @(negedge clk);
            checks.check_value("inst_ready", 32'(inst_ready), 32'h0);
            checks.check_value("exit_flag", 32'(exit_flag), 32'h0);
        end
        @(negedge clk);
        checks.check_value("inst_ready", 32'(inst_ready), 32'h1);
    endtask

    task automatic run_row(input stim_row_t r);
        exec_cmd_t cmd;
        if (r.wb_mode == wb_before) begin
            pulse_writeback(r.wb_addr, r.wb_value);
        end
        if (r.jump_en) begin
            pulse_mispredict();
        end
        inst_valid = 1'b1;
        inst_data = r.word;
        inst_pc = r.pc;
        inst_jump_flag = r.jflag;
        // hazard must hold the word until its writeback arrives
        if (r.wb_mode == wb_during) begin
            repeat (3) begin
                #1;
                checks.check_value("inst_ready", 32'(inst_ready), 32'h0);
                @(negedge clk);
            end
            pulse_writeback(r.wb_addr, r.wb_value);
        end
        #1;
        while (inst_ready !== 1'b1) begin
            @(negedge clk);
            #1;
        end
        if (r.kind == kind_issue) begin
            cmd.op_class = r.cls;
            cmd.funct3 = r.word[14:12];
            cmd.rd = r.rd;
            cmd.rd_tag = r.tag;
            cmd.rs1_value = r.rs1v;
            cmd.rs2_value = r.rs2v;
            cmd.imm = r.imm;
            cmd.pc = r.pc;
            cmd.jump_flag = epoch;
            checks.push_expected(cmd);
            expected_retired++;
        end
        @(posedge clk);
        @(negedge clk);
        inst_valid = 1'b0;
        if (r.kind == kind_exit) begin
            checks.check_value("exit_flag", 32'(exit_flag), 32'h1);
            checks.check_value("exit_code", 32'(exit_code), 32'(r.code));
        end
        @(negedge clk);
        checks.check_value("retired_count", retired_count, expected_retired);
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        inst_data = '0;
        inst_pc = '0;
        inst_jump_flag = '0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_value = '0;
        jump_valid = 1'b0;
        jump_mispredict = 1'b0;
        epoch = '0;
        expected_retired = 0;

        // first add after the sweep reads cleared registers and writes x5
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), 32'h100, 2'd0, wb_none, 5'd0, 0, 0,
                kind_issue, OP_ALU_REG, 5'd5, 3'd0, 32'h0, 32'h0, 32'h0, 8'h0);
        add_row(i_type(12'd3, 5'd5, 3'd0, 5'd0, 7'b0010011), 32'h104, 2'd0, wb_before,
                5'd5, 32'h1234_5678, 0,
                kind_issue, OP_ALU_IMM, 5'd0, 3'd0, 32'h1234_5678, 32'h0, 32'h3, 8'h0);
        // x0 ignores the writeback
        add_row(r_type(7'h00, 5'd5, 5'd0, 3'd0, 5'd0), 32'h108, 2'd0, wb_before,
                5'd0, 32'hdead_beef, 0,
                kind_issue, OP_ALU_REG, 5'd0, 3'd0, 32'h0, 32'h1234_5678, 32'h0, 8'h0);
        // lw x6, 8(x5) leaves x6 outstanding
        add_row(i_type(12'd8, 5'd5, 3'd2, 5'd6, 7'b0000011), 32'h10c, 2'd0, wb_none, 5'd0, 0, 0,
                kind_issue, OP_LOAD, 5'd6, 3'd0, 32'h1234_5678, 32'h0, 32'h8, 8'h0);
        // add x6, x6, x0 stalls until x6 comes back, second issue to x6
        add_row(r_type(7'h00, 5'd0, 5'd6, 3'd0, 5'd6), 32'h110, 2'd0, wb_during,
                5'd6, 32'h55, 0,
                kind_issue, OP_ALU_REG, 5'd6, 3'd1, 32'h55, 32'h0, 32'h0, 8'h0);
        // old epoch after the mispredict, swallowed despite busy x6
        add_row(i_type(12'd1, 5'd6, 3'd0, 5'd10, 7'b0010011), 32'h114, 2'd0, wb_none, 5'd0, 0, 1,
                kind_drop, OP_ALU_IMM, 5'd10, 3'd0, 32'h0, 32'h0, 32'h0, 8'h0);
        // addi x10 leaves a0 waiting for the writeback before ebreak
        add_row(i_type(12'd1, 5'd6, 3'd0, 5'd10, 7'b0010011), 32'h114, 2'd1, wb_before,
                5'd6, 32'h99, 0,
                kind_issue, OP_ALU_IMM, 5'd10, 3'd0, 32'h99, 32'h0, 32'h1, 8'h0);
        // ebreak exits with the low byte of a0
        add_row(32'h0010_0073, 32'h118, 2'd1, wb_before, 5'd10, 32'h0000_012a, 0,
                kind_exit, OP_EBREAK, 5'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h2a);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), 32'h11c, 2'd1, wb_none, 5'd0, 0, 0,
                kind_drop, OP_ALU_REG, 5'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h0);
        // second run, unknown major opcode
        add_row(32'hffff_ffff, 32'h200, 2'd0, wb_none, 5'd0, 0, 0,
                kind_exit, OP_ILLEGAL, 5'd0, 3'd0, 32'h0, 32'h0, 32'h0, 8'h01);

        issued_rows = 0;
        for (int i = 0; i < num_rows - 1; i++) begin
            if (rows[i].kind == kind_issue) begin
                issued_rows++;
            end
        end

        reset_and_sweep();
        for (int i = 0; i < num_rows - 1; i++) begin
            run_row(rows[i]);
        end
        checks.check_value("retired_count", retired_count, issued_rows);
        checks.check_drained();

        reset_and_sweep();
        run_row(rows[num_rows - 1]);
        checks.check_value("retired_count", retired_count, 32'h0);
        checks.check_drained();

        $display("%0d commands seen, %0d errors", checks.command_count, checks.error_count);
        if (checks.error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
